//--- list.f
+incdir+common
common/fir_pkg.sv
src/fir_ctrl/fir_ctrl.sv
src/fir_mem/fir_tap_mem.sv
src/fir_mem/fir_sample_line.sv
src/fir_mac/fir_mac.sv
src/fir_top.sv
verif/fir_tb.sv

//--- Makefile
# Verilator build and run of the FIR core testbench

VERILATOR ?= verilator
FLAGS     ?= --binary --timing -Wno-fatal -j 0
TOP       ?= fir_tb
FILELIST  ?= list.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

//--- verif/fir_tb.sv
////////////////////
// Self-checking testbench of the streaming FIR core
// Runs three batches with random gaps and back-pressure against a software model
////////////////////
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_tb;
  import fir_pkg::*;

  localparam int CLK_HALF = 50;
  localparam int SEED     = 71023;

  // The watchdog budget is derived from the sum of the batch sizes
  localparam int SMP_A           = 40;
  localparam int SMP_B           = 30;
  localparam int SMP_C           = 36;
  localparam int TOTAL_SMP       = SMP_A + SMP_B + SMP_C;
  localparam int WATCHDOG_CYCLES = TOTAL_SMP * (`FIR_MAX_TAPS + 8) * 4 + 2000;

  logic      clk;
  logic      rst_n;
  logic      tap_we;
  tap_idx_t  tap_waddr;
  coef_t     tap_wdata;
  logic      ap_start;
  tap_cnt_t  tap_num;
  smp_cnt_t  data_num;
  logic      ap_done;
  logic      clear_busy;
  logic      ss_tvalid;
  sample_t   ss_tdata;
  logic      ss_tready;
  logic      sm_tvalid;
  acc_t      sm_tdata;
  logic      sm_tlast;
  logic      sm_tready;

  // One seed for each random stream of values, input gaps and output back-pressure
  int data_seed;
  int gap_seed;
  int rdy_seed;

  int value_errors;
  int protocol_errors;

  // Stimulus of the current batch and the sums the model expects from it
  int     coefs [`FIR_MAX_TAPS];
  int     xs [1024];
  longint exp_q [$];

  // Monitor state
  bit   quiet;
  bit   stall_prev;
  acc_t tdata_prev;
  logic tlast_prev;

  fir_top u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .tap_we     (tap_we),
    .tap_waddr  (tap_waddr),
    .tap_wdata  (tap_wdata),
    .ap_start   (ap_start),
    .tap_num    (tap_num),
    .data_num   (data_num),
    .ap_done    (ap_done),
    .clear_busy (clear_busy),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .ss_tready  (ss_tready),
    .sm_tvalid  (sm_tvalid),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .sm_tready  (sm_tready)
  );

  initial begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Fail %s at %0t ns: got 0x%h, expected 0x%h", name, $time, got, exp);
      value_errors++;
    end
  endtask

  task automatic report_fault(input string what);
    $display("Protocol fault at %0t ns: %s", $time, what);
    protocol_errors++;
  endtask

  // Outputs and stimulus are looked at on the falling edge, half a cycle after they change
  always @(negedge clk) begin
    if (rst_n) begin
      // Between reset or done and the next start nothing may move
      if (quiet && (ss_tready || sm_tvalid || sm_tlast || ap_done || clear_busy)) begin
        report_fault("an output went high while the core should be idle");
      end
      if (ap_start) begin
        quiet = 1'b0;
      end
      if (ap_done) begin
        quiet = 1'b1;
      end
      // Whether the accept is the last one is checked where outputs are counted
      if (ap_done && !(sm_tvalid && sm_tready)) begin
        report_fault("ap_done pulsed in a cycle without an output accept");
      end
      if (clear_busy && ss_tready) begin
        report_fault("ss_tready was high during the clear phase");
      end
      // A stalled output must be presented again unchanged
      if (stall_prev) begin
        if (!sm_tvalid) begin
          report_fault("sm_tvalid dropped before the output was accepted");
        end else if (sm_tdata !== tdata_prev || sm_tlast !== tlast_prev) begin
          report_fault("sm_tdata or sm_tlast changed while the output was stalled");
        end
      end
      stall_prev = sm_tvalid && !sm_tready;
      tdata_prev = sm_tdata;
      tlast_prev = sm_tlast;
    end
  end

  ////////////////////
  // Stimulus
  ////////////////////

  task automatic load_taps(input int ntaps);
    for (int k = 0; k < ntaps; k++) begin
      @(posedge clk);
      #1;
      tap_we    = 1'b1;
      tap_waddr = tap_idx_t'(k);
      tap_wdata = coef_t'(coefs[k]);
    end
    @(posedge clk);
    #1;
    tap_we = 1'b0;
  endtask

  // Counts clear cycles from the start edge until the input side opens
  task automatic count_clear(input int ntaps);
    int busy;
    int waited;
    busy   = 0;
    waited = 0;
    @(negedge clk);
    while (!ss_tready && waited < 4 * `FIR_MAX_TAPS) begin
      if (clear_busy) begin
        busy++;
      end
      waited++;
      @(negedge clk);
    end
    if (!ss_tready) begin
      report_fault("ss_tready never rose after the start pulse");
    end
    check_val("clear_busy cycles", busy, ntaps);
  endtask

  task automatic drive_samples(input int nsmp);
    int gap;
    @(posedge clk);
    #1;
    for (int i = 0; i < nsmp; i++) begin
      gap = {$random(gap_seed)} % 4;
      repeat (gap) begin
        @(posedge clk);
        #1;
      end
      ss_tvalid = 1'b1;
      ss_tdata  = sample_t'(xs[i]);
      // Handshake happens on the edge after ready is seen
      @(negedge clk);
      while (!ss_tready) begin
        @(negedge clk);
      end
      @(posedge clk);
      #1;
      ss_tvalid = 1'b0;
    end
  endtask

  // Ready is high in about three cycles out of four
  task automatic accept_outputs(input int nsmp);
    int     got;
    longint got_sum;
    longint exp_sum;
    bit     is_last;
    got = 0;
    while (got < nsmp) begin
      @(posedge clk);
      #1;
      sm_tready = ({$random(rdy_seed)} % 4) != 0;
      @(negedge clk);
      if (sm_tvalid && sm_tready) begin
        is_last = (got == nsmp - 1);
        got_sum = sm_tdata;
        exp_sum = exp_q.pop_front();
        check_val("sm_tdata", got_sum, exp_sum);
        check_val("sm_tlast", sm_tlast, is_last);
        check_val("ap_done", ap_done, is_last);
        got++;
      end
    end
    @(posedge clk);
    #1;
    sm_tready = 1'b0;
  endtask

  // Full scale sets every value to the most negative number, so the sum
  // climbs by 2**30 per tap and needs the guard bits
  task automatic run_batch(input int ntaps, input int nsmp, input bit full_scale);
    shortint v;
    longint  sum;
    $display("Batch with %0d taps and %0d samples", ntaps, nsmp);
    for (int k = 0; k < ntaps; k++) begin
      v        = shortint'($random(data_seed));
      coefs[k] = full_scale ? -32768 : int'(v);
    end
    for (int n = 0; n < nsmp; n++) begin
      v     = shortint'($random(data_seed));
      xs[n] = full_scale ? -32768 : int'(v);
    end

    // Direct form sum with zero history before the first sample
    exp_q.delete();
    for (int n = 0; n < nsmp; n++) begin
      sum = 0;
      for (int k = 0; k < ntaps; k++) begin
        if (n >= k) begin
          sum += longint'(coefs[k]) * longint'(xs[n-k]);
        end
      end
      exp_q.push_back(sum);
    end

    load_taps(ntaps);
    @(posedge clk);
    #1;
    ap_start = 1'b1;
    tap_num  = tap_cnt_t'(ntaps);
    data_num = smp_cnt_t'(nsmp);
    @(posedge clk);
    #1;
    ap_start = 1'b0;
    count_clear(ntaps);
    fork
      drive_samples(nsmp);
      accept_outputs(nsmp);
    join
  endtask

  ////////////////////
  // Test sequence
  ////////////////////

  initial begin
    int ntaps_a;
    int ntaps_b;
    data_seed       = SEED;
    gap_seed        = SEED + 1;
    rdy_seed        = SEED + 2;
    value_errors    = 0;
    protocol_errors = 0;
    quiet           = 1'b1;
    stall_prev      = 1'b0;
    rst_n     = 1'b0;
    tap_we    = 1'b0;
    tap_waddr = '0;
    tap_wdata = '0;
    ap_start  = 1'b0;
    tap_num   = '0;
    data_num  = '0;
    ss_tvalid = 1'b0;
    ss_tdata  = '0;
    sm_tready = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // The monitor expects every output to stay low through this idle stretch
    repeat (8) @(posedge clk);

    // Second tap count always differs from the first
    ntaps_a = 1 + ({$random(data_seed)} % `FIR_MAX_TAPS);
    ntaps_b = ((ntaps_a + {$random(data_seed)} % (`FIR_MAX_TAPS - 1)) % `FIR_MAX_TAPS) + 1;
    run_batch(ntaps_a, SMP_A, 1'b0);
    run_batch(ntaps_b, SMP_B, 1'b0);
    run_batch(`FIR_MAX_TAPS, SMP_C, 1'b1);
    repeat (8) @(posedge clk);

    $display("Error counts: %0d value mismatches, %0d protocol faults",
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

  // Budget covers the longest taps per sample with gaps and back-pressure
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

//--- src/fir_top.sv
////////////////////
// Top level of the streaming FIR core
// Joins controller, tap memory, delay line and MAC pipeline
////////////////////
`timescale 1ns/1ps

module fir_top (
  input  logic               clk,
  input  logic               rst_n,

  // Coefficient load, only while idle
  input  logic               tap_we,
  input  fir_pkg::tap_idx_t  tap_waddr,
  input  fir_pkg::coef_t     tap_wdata,

  // Batch control
  input  logic               ap_start,
  input  fir_pkg::tap_cnt_t  tap_num,
  input  fir_pkg::smp_cnt_t  data_num,
  output logic               ap_done,
  output logic               clear_busy,

  // Input sample stream
  input  logic               ss_tvalid,
  input  fir_pkg::sample_t   ss_tdata,
  output logic               ss_tready,

  // Output sum stream
  output logic               sm_tvalid,
  output fir_pkg::acc_t      sm_tdata,
  output logic               sm_tlast,
  input  logic               sm_tready
);

  // Issue stage to memories and pipeline
  logic               clr_en;
  fir_pkg::tap_idx_t  clr_idx;
  logic               shift_en;
  fir_pkg::sample_t   shift_data;
  fir_pkg::tap_idx_t  rd_idx;
  fir_pkg::mac_cmd_t  cmd;

  // Memory read data into the multiply stage
  fir_pkg::coef_t     rd_coef;
  fir_pkg::sample_t   rd_sample;

  // Back-pressure and completion from the pipeline
  logic               hold;
  logic               batch_done;

  // The batch finishes with the accept of its final sum
  assign ap_done = batch_done;

  fir_ctrl u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .ap_start   (ap_start),
    .tap_num    (tap_num),
    .data_num   (data_num),
    .ss_tvalid  (ss_tvalid),
    .ss_tdata   (ss_tdata),
    .hold       (hold),
    .batch_done (batch_done),
    .ss_tready  (ss_tready),
    .clear_busy (clear_busy),
    .clr_en     (clr_en),
    .clr_idx    (clr_idx),
    .shift_en   (shift_en),
    .shift_data (shift_data),
    .rd_idx     (rd_idx),
    .cmd        (cmd)
  );

  fir_tap_mem u_tap_mem (
    .clk     (clk),
    .rst_n   (rst_n),
    .we      (tap_we),
    .waddr   (tap_waddr),
    .wdata   (tap_wdata),
    .rd_idx  (rd_idx),
    .hold    (hold),
    .rd_coef (rd_coef)
  );

  fir_sample_line u_sample_line (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en   (shift_en),
    .shift_data (shift_data),
    .clr_en     (clr_en),
    .clr_idx    (clr_idx),
    .rd_idx     (rd_idx),
    .hold       (hold),
    .rd_sample  (rd_sample)
  );

  fir_mac u_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .rd_coef    (rd_coef),
    .rd_sample  (rd_sample),
    .sm_tready  (sm_tready),
    .hold       (hold),
    .sm_tvalid  (sm_tvalid),
    .sm_tdata   (sm_tdata),
    .sm_tlast   (sm_tlast),
    .batch_done (batch_done)
  );

endmodule

//--- src/fir_mac/fir_mac.sv
////////////////////
// Multiply-accumulate pipeline with the output stream register
// Read tag, multiply, accumulate, then hand the sum to the stream
////////////////////
`timescale 1ns/1ps

module fir_mac (
  input  logic               clk,
  input  logic               rst_n,
  input  fir_pkg::mac_cmd_t  cmd,
  input  fir_pkg::coef_t     rd_coef,
  input  fir_pkg::sample_t   rd_sample,
  input  logic               sm_tready,
  output logic               hold,
  output logic               sm_tvalid,
  output fir_pkg::acc_t      sm_tdata,
  output logic               sm_tlast,
  output logic               batch_done
);
  import fir_pkg::*;

  // Tag of the read stage, lines up with the registered memory data
  mac_cmd_t cmd_rd;

  // Multiply stage
  mac_cmd_t cmd_mul;
  product_t prod_q;

  // Accumulate stage
  acc_t acc_q;
  acc_t acc_nxt;
  acc_t prod_ext;

  ////////////////////
  // Stall and completion
  ////////////////////

  // A sum waiting on the stream freezes every stage behind it
  assign hold = sm_tvalid && !sm_tready;

  // Accept of the sum tagged final ends the batch
  assign batch_done = sm_tvalid && sm_tready && sm_tlast;

  ////////////////////
  // Read and multiply stages
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_rd  <= '0;
      cmd_mul <= '0;
    end else if (!hold) begin
      cmd_rd  <= cmd;
      cmd_mul <= cmd_rd;
    end
  end

  // Both operands are signed, the product is exact at twice the data width
  always_ff @(posedge clk) begin
    if (!hold) begin
      prod_q <= rd_coef * rd_sample;
    end
  end

  ////////////////////
  // Accumulate stage
  ////////////////////

  // Sign extension into the guard bits
  assign prod_ext = acc_t'(prod_q);

  // First tap restarts the sum, later taps add onto it
  assign acc_nxt = cmd_mul.first ? prod_ext : acc_q + prod_ext;

  always_ff @(posedge clk) begin
    if (!hold && cmd_mul.valid) begin
      acc_q <= acc_nxt;
    end
  end

  ////////////////////
  // Output register
  ////////////////////

  // The finished sum skips the accumulator and loads here on the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_tvalid <= 1'b0;
      sm_tlast  <= 1'b0;
    end else if (!hold) begin
      // Empty or just accepted, take the next sum if one completes now
      sm_tvalid <= cmd_mul.valid && cmd_mul.last;
      sm_tlast  <= cmd_mul.valid && cmd_mul.last && cmd_mul.final_sum;
    end
  end

  // Data stays stable under hold, the stream sees it unchanged until the accept
  always_ff @(posedge clk) begin
    if (!hold && cmd_mul.valid && cmd_mul.last) begin
      sm_tdata <= acc_nxt;
    end
  end

endmodule

//--- src/fir_mem/fir_sample_line.sv
////////////////////
// Sample delay line of the FIR core
// Entry k holds the sample taken k inputs ago, read by tap index
////////////////////
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_sample_line (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               shift_en,
  input  fir_pkg::sample_t   shift_data,
  input  logic               clr_en,
  input  fir_pkg::tap_idx_t  clr_idx,
  input  fir_pkg::tap_idx_t  rd_idx,
  input  logic               hold,
  output fir_pkg::sample_t   rd_sample
);
  import fir_pkg::*;

  sample_t line [`FIR_MAX_TAPS];

  ////////////////////
  // Line storage
  ////////////////////

  // Shift and clear never overlap, the controller runs them in separate states
  always_ff @(posedge clk) begin
    if (shift_en) begin
      // Newest sample lands in entry 0, everything else moves one deeper
      line[0] <= shift_data;
      for (int k = 1; k < `FIR_MAX_TAPS; k++) begin
        line[k] <= line[k-1];
      end
    end else if (clr_en) begin
      // One entry per cycle, only the entries the batch reads get zeroed
      line[clr_idx] <= '0;
    end
  end

  ////////////////////
  // Read port
  ////////////////////

  // Captures the entry before any shift on the same edge,
  // so a tap read always sees the history of the sample being filtered
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_sample <= '0;
    end else if (!hold) begin
      rd_sample <= line[rd_idx];
    end
  end

endmodule

//--- src/fir_mem/fir_tap_mem.sv
////////////////////
// Coefficient register file
// Written while idle, read one tap per cycle by the issue stage
////////////////////
`timescale 1ns/1ps
`include "fir_cfg.svh"

module fir_tap_mem (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               we,
  input  fir_pkg::tap_idx_t  waddr,
  input  fir_pkg::coef_t     wdata,
  input  fir_pkg::tap_idx_t  rd_idx,
  input  logic               hold,
  output fir_pkg::coef_t     rd_coef
);
  import fir_pkg::*;

  // One coefficient per tap position
  coef_t mem [`FIR_MAX_TAPS];

  // Unwritten taps read back as zero and add nothing to a sum
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `FIR_MAX_TAPS; i++) begin
        mem[i] <= '0;
      end
      rd_coef <= '0;
    end else begin
      // A write is visible to reads from the next cycle on
      if (we) begin
        mem[waddr] <= wdata;
      end

      // Read register is the first pipeline stage and freezes with it
      if (!hold) begin
        rd_coef <= mem[rd_idx];
      end
    end
  end

endmodule

//--- src/fir_ctrl/fir_ctrl.sv
////////////////////
// Controller and issue stage of the FIR core
// Clears the delay line, takes samples and issues one tap per cycle
////////////////////
`timescale 1ns/1ps

module fir_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ap_start,
  input  fir_pkg::tap_cnt_t  tap_num,
  input  fir_pkg::smp_cnt_t  data_num,
  input  logic               ss_tvalid,
  input  fir_pkg::sample_t   ss_tdata,
  input  logic               hold,
  input  logic               batch_done,
  output logic               ss_tready,
  output logic               clear_busy,
  output logic               clr_en,
  output fir_pkg::tap_idx_t  clr_idx,
  output logic               shift_en,
  output fir_pkg::sample_t   shift_data,
  output fir_pkg::tap_idx_t  rd_idx,
  output fir_pkg::mac_cmd_t  cmd
);
  import fir_pkg::*;

  fir_state_e state;
  fir_state_e state_nxt;

  // Batch configuration, captured on the start pulse
  tap_cnt_t tap_num_q;
  smp_cnt_t data_num_q;

  tap_idx_t clr_cnt;
  tap_idx_t tap_cnt;
  smp_cnt_t smp_cnt;

  tap_idx_t last_tap;
  smp_cnt_t last_smp;
  logic     clr_done;
  logic     issue;
  logic     issue_last;

  // Highest tap index in use, tap_num of 32 still maps to index 31
  assign last_tap = tap_idx_t'(tap_num_q - 1'b1);
  assign last_smp = data_num_q - 1'b1;

  // Clearing ends after exactly tap_num entries
  assign clr_done = (state == CLEAR) && (clr_cnt == last_tap);

  // A held output blocks every new tap
  assign issue      = (state == MAC) && !hold;
  assign issue_last = issue && (tap_cnt == last_tap);

  ////////////////////
  // State machine
  ////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (ap_start) state_nxt = CLEAR;
      end
      CLEAR: begin
        if (clr_done) state_nxt = WAIT_SAMPLE;
      end
      WAIT_SAMPLE: begin
        // ss_tready is high here, so valid alone is the handshake
        if (ss_tvalid) state_nxt = MAC;
      end
      MAC: begin
        if (issue_last) state_nxt = (smp_cnt == last_smp) ? DRAIN : WAIT_SAMPLE;
      end
      DRAIN: begin
        // Leave on the accept of the sum tagged final
        if (batch_done) state_nxt = IDLE;
      end
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= IDLE;
      tap_num_q  <= '0;
      data_num_q <= '0;
      clr_cnt    <= '0;
      tap_cnt    <= '0;
      smp_cnt    <= '0;
    end else begin
      state <= state_nxt;

      // Counts are sampled once per batch
      if ((state == IDLE) && ap_start) begin
        tap_num_q  <= tap_num;
        data_num_q <= data_num;
      end

      // Walks the delay line entries during CLEAR, rests at zero otherwise
      if (state == CLEAR) begin
        clr_cnt <= clr_cnt + 1'b1;
      end else begin
        clr_cnt <= '0;
      end

      // Tap index wraps to zero after the last tap of each sample
      if (state == IDLE) begin
        tap_cnt <= '0;
      end else if (issue) begin
        tap_cnt <= (tap_cnt == last_tap) ? '0 : tap_cnt + 1'b1;
      end

      // One sample is consumed when its last tap goes out
      if (state == IDLE) begin
        smp_cnt <= '0;
      end else if (issue_last) begin
        smp_cnt <= smp_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // Outputs
  ////////////////////

  assign ss_tready  = (state == WAIT_SAMPLE);
  assign clear_busy = (state == CLEAR);

  // Clear port of the delay line
  assign clr_en  = (state == CLEAR);
  assign clr_idx = clr_cnt;

  // An accepted sample shifts straight into the line
  assign shift_en   = ss_tvalid && ss_tready;
  assign shift_data = ss_tdata;

  // Both memories are read with the same index
  assign rd_idx = tap_cnt;

  // Tag for the tap read in this cycle
  always_comb begin
    cmd.valid     = issue;
    cmd.first     = issue && (tap_cnt == '0);
    cmd.last      = issue_last;
    cmd.final_sum = issue_last && (smp_cnt == last_smp);
  end

endmodule

//--- common/fir_pkg.sv
////////////////////
// Shared types of the FIR core
// Modules import it in their body and use scoped names on their ports
////////////////////
`include "fir_cfg.svh"

package fir_pkg;

  ////////////////////
  // Datapath types
  ////////////////////

  // Input sample and tap coefficient, both two's complement
  typedef logic signed [`FIR_DATA_W-1:0] sample_t;
  typedef logic signed [`FIR_DATA_W-1:0] coef_t;

  // Exact product of one coefficient and one sample
  typedef logic signed [2*`FIR_DATA_W-1:0] product_t;

  // Running sum with guard bits above the product width
  typedef logic signed [`FIR_ACC_W-1:0] acc_t;

  ////////////////////
  // Index and count types
  ////////////////////

  // Address of one tap or one delay line entry
  typedef logic [`FIR_TAP_W-1:0] tap_idx_t;

  // Tap count, one bit wider so a full memory of taps fits
  typedef logic [`FIR_TAP_W:0] tap_cnt_t;

  // Number of samples in a batch
  typedef logic [`FIR_CNT_W-1:0] smp_cnt_t;

  ////////////////////
  // Control types
  ////////////////////

  // Controller states, from configuration through the final drain
  typedef enum logic [2:0] {
    IDLE,
    CLEAR,
    WAIT_SAMPLE,
    MAC,
    DRAIN
  } fir_state_e;

  // Tag issued alongside every tap read, it follows the data down the pipe
  typedef struct packed {
    logic valid;      // A tap was issued in this slot
    logic first;      // Tap 0, the sum restarts here
    logic last;       // Tap tap_num-1, the sum is complete after this one
    logic final_sum;  // Last tap of the last sample in the batch
  } mac_cmd_t;

endpackage

//--- common/fir_cfg.svh
////////////////////
// Build-time sizing of the FIR core
// Pulled in by the package and by the modules that size their storage
////////////////////
`ifndef FIR_CFG_SVH
`define FIR_CFG_SVH

// Width of one sample and of one coefficient
`define FIR_DATA_W 16

// Depth of the tap memory and of the sample delay line
`define FIR_MAX_TAPS 32

// Bits needed to address one of the FIR_MAX_TAPS entries
`define FIR_TAP_W 5

// Largest batch is 2**FIR_CNT_W - 1 samples
`define FIR_CNT_W 10

// Full product width plus one guard bit per doubling of the tap count,
// so a sum of FIR_MAX_TAPS full-scale products never overflows
`define FIR_ACC_W (2 * `FIR_DATA_W + `FIR_TAP_W)

`endif
